//--- common/lsu_pkg.sv
package lsu_pkg;

  //////////////////////////////////////////////////
  // Core side widths
  //////////////////////////////////////////////////

  // Data and operand word
  typedef logic [31:0] word_t;

  // Byte address
  typedef logic [31:0] addr_t;

  // Byte position inside a word
  typedef logic [1:0] offset_t;

  // Access size code
  typedef logic [1:0] size_t;

  // Size encodings as seen on req_i.size
  localparam size_t SIZE_BYTE = 2'd0;
  localparam size_t SIZE_HALF = 2'd1;
  localparam size_t SIZE_WORD = 2'd2;

  //////////////////////////////////////////////////
  // Core operation
  //////////////////////////////////////////////////

  // One load or store as handed over by the core
  typedef struct packed {
    word_t op_a;
    word_t op_b;
    word_t wdata;
    logic  we;
    size_t size;
    logic  sext;
  } lsu_req_t;

  // Phase of a possibly split access
  typedef enum logic {
    SPLIT_FIRST,
    SPLIT_SECOND
  } lsu_split_e;

endpackage

//--- common/mem_pkg.sv
package mem_pkg;

  //////////////////////////////////////////////////
  // Memory bus
  //////////////////////////////////////////////////

  // One enable per byte lane
  typedef logic [3:0] be_t;

  // Request towards data memory, address is always word aligned
  typedef struct packed {
    lsu_pkg::addr_t addr;
    logic           we;
    be_t            be;
    lsu_pkg::word_t wdata;
  } mem_req_t;

  // Transactions allowed in flight
  localparam int MAX_OUTSTANDING = 2;

  // Width of the in-flight counter
  localparam int CNT_W = 2;

endpackage

//--- logic/outstanding_cnt.sv
`timescale 1ns/1ns

module outstanding_cnt #(
  parameter int MAX = mem_pkg::MAX_OUTSTANDING
) (
  input  logic clk,
  input  logic rst_n,
  input  logic inc_i,
  input  logic dec_i,
  output logic full_o,
  output logic empty_o
);

  typedef logic [mem_pkg::CNT_W-1:0] cnt_t;

  // Limit in counter width
  localparam cnt_t MAX_CNT = cnt_t'(MAX);

  cnt_t cnt_q;
  cnt_t cnt_d;

  // Grant and response in one cycle cancel out
  always_comb
  begin
    case ({inc_i, dec_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else
      cnt_q <= cnt_d;
  end

  // Full blocks new phases, empty feeds busy
  assign full_o  = (cnt_q == MAX_CNT);
  assign empty_o = (cnt_q == '0);

endmodule

//--- lsu/lsu_split_fsm.sv
`timescale 1ns/1ns

module lsu_split_fsm (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req_valid_i,
  input  lsu_pkg::size_t   size_i,
  input  lsu_pkg::offset_t offset_i,
  input  logic             grant_i,
  output logic             second_o,
  output logic             needs_split_o,
  output logic             last_o
);

  lsu_pkg::lsu_split_e state_q;
  lsu_pkg::lsu_split_e state_d;

  logic word_cross;
  logic half_cross;

  //////////////////////////////////////////////////
  // Split detection
  //////////////////////////////////////////////////

  // Word not on a word boundary spills into next word
  assign word_cross = (size_i == lsu_pkg::SIZE_WORD) && (offset_i != 2'd0);

  // Halfword only spills when it starts in the top lane
  assign half_cross = (size_i == lsu_pkg::SIZE_HALF) && (offset_i == 2'd3);

  // A split is only flagged while in the first phase
  assign needs_split_o = (state_q == lsu_pkg::SPLIT_FIRST) && (word_cross || half_cross);

  // Non-split accesses and second phases both finish the operation
  assign last_o   = !needs_split_o;
  assign second_o = (state_q == lsu_pkg::SPLIT_SECOND);

  //////////////////////////////////////////////////
  // Phase tracking
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    if (!req_valid_i)
    begin
      // No operation pending, next one starts fresh
      state_d = lsu_pkg::SPLIT_FIRST;
    end
    else if (grant_i)
    begin
      if (needs_split_o)
        state_d = lsu_pkg::SPLIT_SECOND;
      else
        state_d = lsu_pkg::SPLIT_FIRST;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= lsu_pkg::SPLIT_FIRST;
    else
      state_q <= state_d;
  end

endmodule

//--- lsu/lsu_req_align.sv
`timescale 1ns/1ns

module lsu_req_align (
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              second_i,
  output lsu_pkg::offset_t  offset_o,
  output mem_pkg::mem_req_t mem_req_o
);

  lsu_pkg::addr_t addr;
  lsu_pkg::addr_t word_addr;
  lsu_pkg::word_t wdata_rot;
  mem_pkg::be_t   be_base;
  logic [7:0]     be_wide;

  //////////////////////////////////////////////////
  // Address
  //////////////////////////////////////////////////

  // Effective address
  assign addr     = req_i.op_a + req_i.op_b;
  assign offset_o = addr[1:0];

  // Word aligned, second phase targets the following word
  assign word_addr = {addr[31:2], 2'b00} + (second_i ? 32'd4 : 32'd0);

  //////////////////////////////////////////////////
  // Byte enables
  //////////////////////////////////////////////////

  // Lanes covered by the access when it starts at lane 0
  always_comb
  begin
    case (req_i.size)
      lsu_pkg::SIZE_BYTE: be_base = 4'b0001;
      lsu_pkg::SIZE_HALF: be_base = 4'b0011;
      default:            be_base = 4'b1111;
    endcase
  end

  // Shift across two words, upper nibble is what spills over
  assign be_wide = {4'b0000, be_base} << offset_o;

  //////////////////////////////////////////////////
  // Write data
  //////////////////////////////////////////////////

  // Rotate left so data byte 0 sits on the lane at the offset
  always_comb
  begin
    case (offset_o)
      2'd0:    wdata_rot = req_i.wdata;
      2'd1:    wdata_rot = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'd2:    wdata_rot = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: wdata_rot = {req_i.wdata[7:0], req_i.wdata[31:8]};
    endcase
  end

  // Same rotated data serves both phases
  always_comb
  begin
    mem_req_o.addr  = word_addr;
    mem_req_o.we    = req_i.we;
    mem_req_o.be    = second_i ? be_wide[7:4] : be_wide[3:0];
    mem_req_o.wdata = wdata_rot;
  end

endmodule

//--- lsu/lsu_rdata_align.sv
`timescale 1ns/1ns

module lsu_rdata_align (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push_i,
  input  lsu_pkg::lsu_req_t req_i,
  input  lsu_pkg::offset_t  offset_i,
  input  logic              last_i,
  input  logic              rsp_valid_i,
  input  lsu_pkg::word_t    rsp_rdata_i,
  output logic              rsp_valid_o,
  output lsu_pkg::word_t    rdata_o,
  output logic              pending_o
);

  // One slot per transaction in flight
  localparam int DEPTH = mem_pkg::MAX_OUTSTANDING;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int FILL_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [FILL_W-1:0] fill_t;

  // Per phase load control
  typedef struct packed {
    lsu_pkg::size_t   size;
    logic             sext;
    logic             we;
    lsu_pkg::offset_t offset;
    logic             last;
  } ctrl_t;

  ctrl_t          queue_q [DEPTH];
  ctrl_t          head;
  ptr_t           wr_ptr_q;
  ptr_t           rd_ptr_q;
  fill_t          fill_q;
  lsu_pkg::word_t rdata_q;
  logic [7:0]     byte_val;
  logic [15:0]    half_val;
  lsu_pkg::word_t byte_ext;
  lsu_pkg::word_t half_ext;
  lsu_pkg::word_t word_val;

  //////////////////////////////////////////////////
  // Control queue
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (push_i)
      queue_q[wr_ptr_q] <= '{size: req_i.size, sext: req_i.sext, we: req_i.we,
                             offset: offset_i, last: last_i};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end
    else
    begin
      // Push on grant
      if (push_i)
        wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      // Pop on response
      if (rsp_valid_i)
        rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      case ({push_i, rsp_valid_i})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  // Oldest phase owns the current response
  assign head      = queue_q[rd_ptr_q];
  assign pending_o = (fill_q != '0);

  // First half of a split load
  always_ff @(posedge clk)
  begin
    if (rsp_valid_i && !head.last && !head.we)
      rdata_q <= rsp_rdata_i;
  end

  //////////////////////////////////////////////////
  // Reassembly and extension
  //////////////////////////////////////////////////

  assign byte_val = rsp_rdata_i[{head.offset, 3'b000} +: 8];

  always_comb
  begin
    case (head.offset)
      2'd0:    half_val = rsp_rdata_i[15:0];
      2'd1:    half_val = rsp_rdata_i[23:8];
      2'd2:    half_val = rsp_rdata_i[31:16];
      // Low byte came with the first response
      default: half_val = {rsp_rdata_i[7:0], rdata_q[31:24]};
    endcase
  end

  // Upper bytes of held word below low bytes of new word
  always_comb
  begin
    case (head.offset)
      2'd0:    word_val = rsp_rdata_i;
      2'd1:    word_val = {rsp_rdata_i[7:0], rdata_q[31:8]};
      2'd2:    word_val = {rsp_rdata_i[15:0], rdata_q[31:16]};
      default: word_val = {rsp_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  assign byte_ext = head.sext ? {{24{byte_val[7]}}, byte_val} : {24'h0, byte_val};
  assign half_ext = head.sext ? {{16{half_val[15]}}, half_val} : {16'h0, half_val};

  always_comb
  begin
    case (head.size)
      lsu_pkg::SIZE_BYTE: rdata_o = byte_ext;
      lsu_pkg::SIZE_HALF: rdata_o = half_ext;
      default:            rdata_o = word_val;
    endcase
  end

  // One result per operation
  assign rsp_valid_o = rsp_valid_i && head.last;

endmodule

//--- lsu/lsu_top.sv
`timescale 1ns/1ns

module lsu_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  input  lsu_pkg::lsu_req_t req_i,
  output logic              req_ready_o,
  output logic              mem_req_valid_o,
  output mem_pkg::mem_req_t mem_req_o,
  input  logic              mem_req_ready_i,
  input  logic              mem_rsp_valid_i,
  input  lsu_pkg::word_t    mem_rsp_rdata_i,
  output logic              rsp_valid_o,
  output lsu_pkg::word_t    rsp_rdata_o,
  output logic              busy_o
);

  lsu_pkg::offset_t offset;
  logic             second;
  logic             last;
  logic             grant;
  logic             cnt_full;
  logic             cnt_empty;
  logic             pending;

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  // Hold off new phases while the limit is reached
  assign mem_req_valid_o = req_valid_i && !cnt_full;
  assign grant           = mem_req_valid_o && mem_req_ready_i;

  // Operation leaves the core only with its final phase
  assign req_ready_o = grant && last;

  assign busy_o = req_valid_i || !cnt_empty || pending;

  //////////////////////////////////////////////////
  // Request path
  //////////////////////////////////////////////////

  lsu_req_align u_req_align (
    .req_i     (req_i),
    .second_i  (second),
    .offset_o  (offset),
    .mem_req_o (mem_req_o)
  );

  // needs_split is folded into last inside the FSM
  lsu_split_fsm u_split_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .size_i        (req_i.size),
    .offset_i      (offset),
    .grant_i       (grant),
    .second_o      (second),
    .needs_split_o (),
    .last_o        (last)
  );

  outstanding_cnt #(
    .MAX (mem_pkg::MAX_OUTSTANDING)
  ) u_outstanding_cnt (
    .clk     (clk),
    .rst_n   (rst_n),
    .inc_i   (grant),
    .dec_i   (mem_rsp_valid_i),
    .full_o  (cnt_full),
    .empty_o (cnt_empty)
  );

  //////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////

  lsu_rdata_align u_rdata_align (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (grant),
    .req_i       (req_i),
    .offset_i    (offset),
    .last_i      (last),
    .rsp_valid_i (mem_rsp_valid_i),
    .rsp_rdata_i (mem_rsp_rdata_i),
    .rsp_valid_o (rsp_valid_o),
    .rdata_o     (rsp_rdata_o),
    .pending_o   (pending)
  );

endmodule

//--- dv/lsu_assertions.sv
`timescale 1ns/1ns

module lsu_assertions (
  input logic              clk,
  input logic              rst_n,
  input logic              mem_req_valid_i,
  input mem_pkg::mem_req_t mem_req_i,
  input logic              mem_req_ready_i,
  input logic              mem_rsp_valid_i,
  input logic              rsp_valid_i
);

  // Failed assertions, read by the testbench top
  int   fail_count = 0;
  int   in_flight;
  logic grant;

  assign grant = mem_req_valid_i && mem_req_ready_i;

  // Independent count of phases waiting for a response
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      in_flight <= 0;
    else
      in_flight <= in_flight + int'(grant) - int'(mem_rsp_valid_i);
  end

  //////////////////////////////////////////////////
  // Protocol properties
  //////////////////////////////////////////////////

  // A waiting request may not move
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_valid_i && !mem_req_ready_i |=> $stable(mem_req_i))
  else
  begin
    $error("mem_req_o changed while waiting for grant");
    fail_count = fail_count + 1;
  end

  // Never more phases in flight than the limit
  limit_kept: assert property (@(posedge clk) disable iff (!rst_n)
    in_flight <= mem_pkg::MAX_OUTSTANDING)
  else
  begin
    $error("more than %0d memory transactions in flight", mem_pkg::MAX_OUTSTANDING);
    fail_count = fail_count + 1;
  end

  // Result only ever answers an issued phase
  rsp_has_source: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_i |-> in_flight != 0)
  else
  begin
    $error("rsp_valid_o high with no transaction in flight");
    fail_count = fail_count + 1;
  end

endmodule

bind lsu_top lsu_assertions u_lsu_assertions (
  .clk             (clk),
  .rst_n           (rst_n),
  .mem_req_valid_i (mem_req_valid_o),
  .mem_req_i       (mem_req_o),
  .mem_req_ready_i (mem_req_ready_i),
  .mem_rsp_valid_i (mem_rsp_valid_i),
  .rsp_valid_i     (rsp_valid_o)
);

//--- dv/lsu_checker.sv
`timescale 1ns/1ns

module lsu_checker (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              req_ready_i,
  input  logic              mem_req_valid_i,
  input  mem_pkg::mem_req_t mem_req_i,
  input  logic              mem_req_ready_i,
  input  logic              rsp_valid_i,
  input  lsu_pkg::word_t    rsp_rdata_i,
  input  logic              busy_i,
  input  logic              drain_i,
  output int                mismatch_cnt_o,
  output int                other_err_cnt_o,
  output int                pending_o,
  output int                results_o
);

  // Byte image of the 64 byte memory model
  logic [7:0]     shadow [64];
  // Expected results in request order
  logic           exp_load_q [$];
  lsu_pkg::word_t exp_data_q [$];
  logic           second;
  logic           started;

  function automatic logic [7:0] init_byte(input int b);
    return 8'(b * 29 + 91);
  endfunction

  function automatic int size_bytes(input lsu_pkg::size_t size);
    if (size == lsu_pkg::SIZE_BYTE)
      return 1;
    else if (size == lsu_pkg::SIZE_HALF)
      return 2;
    return 4;
  endfunction

  initial
  begin
    for (int b = 0; b < 64; b++)
      shadow[b] = init_byte(b);
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, got);
    mismatch_cnt_o = mismatch_cnt_o + 1;
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    other_err_cnt_o = other_err_cnt_o + 1;
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Store writes its bytes, load reads and extends them
  task automatic accept_op(input lsu_pkg::addr_t addr, input int nbytes);
    lsu_pkg::word_t val;
    int             idx;
    val = '0;
    for (int i = 0; i < nbytes; i++)
    begin
      idx = (int'(addr[5:0]) + i) % 64;
      if (req_i.we)
        shadow[idx] = req_i.wdata[8*i +: 8];
      else
        val[8*i +: 8] = shadow[idx];
    end
    if (nbytes == 1)
      val = req_i.sext ? {{24{val[7]}}, val[7:0]} : {24'h0, val[7:0]};
    else if (nbytes == 2)
      val = req_i.sext ? {{16{val[15]}}, val[15:0]} : {16'h0, val[15:0]};
    exp_load_q.push_back(!req_i.we);
    exp_data_q.push_back(val);
  endtask

  // Compare each granted phase with the lane rules
  task automatic check_phase();
    lsu_pkg::addr_t addr;
    lsu_pkg::addr_t exp_addr;
    mem_pkg::be_t   exp_be;
    lsu_pkg::word_t exp_wdata;
    int             off;
    int             nbytes;
    int             k;
    logic           split;
    logic           last;
    addr   = req_i.op_a + req_i.op_b;
    off    = int'(addr[1:0]);
    nbytes = size_bytes(req_i.size);
    split  = (nbytes == 4 && off != 0) || (nbytes == 2 && off == 3);
    if (!(mem_req_valid_i && mem_req_ready_i))
    begin
      if (req_ready_i)
        report_error("req_ready_o is high in a cycle without a granted phase");
    end
    else
    begin
      // Word holding the first byte, next word for the second phase
      exp_addr = addr - 32'(off);
      if (second)
        exp_addr = exp_addr + 32'd4;
      for (int j = 0; j < 4; j++)
      begin
        // Data byte that lands on lane j in this phase
        k = j + (second ? 4 : 0) - off;
        exp_be[j] = (k >= 0) && (k < nbytes);
        exp_wdata[8*j +: 8] = req_i.wdata[8*((j - off) & 3) +: 8];
      end
      last = second || !split;
      if (mem_req_i.addr !== exp_addr)
        report_mismatch("mem_req_o.addr", exp_addr, mem_req_i.addr);
      if (mem_req_i.be !== exp_be)
        report_mismatch("mem_req_o.be", 32'(exp_be), 32'(mem_req_i.be));
      if (mem_req_i.we !== req_i.we)
        report_mismatch("mem_req_o.we", 32'(req_i.we), 32'(mem_req_i.we));
      if (req_i.we && mem_req_i.wdata !== exp_wdata)
        report_mismatch("mem_req_o.wdata", exp_wdata, mem_req_i.wdata);
      if (req_ready_i !== last)
        report_mismatch("req_ready_o", 32'(last), 32'(req_ready_i));
      if (last)
      begin
        accept_op(addr, nbytes);
        second = 1'b0;
      end
      else
        second = 1'b1;
    end
  endtask

  // Oldest expected result owns the response
  task automatic check_result();
    logic           is_load;
    lsu_pkg::word_t exp;
    if (rsp_valid_i)
    begin
      if (exp_load_q.size() == 0)
        report_error("rsp_valid_o is high with no accepted operation waiting");
      else
      begin
        is_load = exp_load_q.pop_front();
        exp     = exp_data_q.pop_front();
        results_o = results_o + 1;
        if (is_load && rsp_rdata_i !== exp)
          report_mismatch("rsp_rdata_o", exp, rsp_rdata_i);
      end
    end
  endtask

  // Outputs at rest after reset and after the last result
  task automatic check_rest();
    if (req_valid_i)
      started = 1'b1;
    if (!started && (req_ready_i || mem_req_valid_i || rsp_valid_i || busy_i))
      report_error("outputs are not low after reset before any request");
    // Busy spans a waiting request and every accepted operation without result
    if ((req_valid_i || exp_load_q.size() != 0) && !busy_i)
      report_error("busy_o is low while an operation is still in progress");
    if (drain_i && busy_i)
      report_error("busy_o is still high after the last result");
  endtask

  // Inputs change just after the rising edge, so sample mid cycle
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      second          = 1'b0;
      started         = 1'b0;
      mismatch_cnt_o  = 0;
      other_err_cnt_o = 0;
      results_o       = 0;
      pending_o       = 0;
    end
    else
    begin
      check_rest();
      check_result();
      check_phase();
      pending_o = exp_load_q.size();
    end
  end

endmodule

//--- dv/lsu_tb.sv
`timescale 1ns/1ns

module lsu_tb;

  localparam int CLK_PERIOD = 20;
  localparam int NUM_OPS = 400;
  // 40 cycles per operation is far above the worst case
  localparam int TIMEOUT_CYCLES = NUM_OPS * 40;
  localparam int MEM_WORDS = 16;

  logic              clk;
  logic              rst_n;
  logic              req_valid;
  lsu_pkg::lsu_req_t req;
  logic              req_ready;
  logic              mem_req_valid;
  mem_pkg::mem_req_t mem_req;
  logic              mem_req_ready;
  logic              mem_rsp_valid;
  lsu_pkg::word_t    mem_rsp_rdata;
  logic              rsp_valid;
  lsu_pkg::word_t    rsp_rdata;
  logic              busy;
  logic              drain;
  int                mismatch_cnt;
  int                other_err_cnt;
  int                pending;
  int                results;

  integer            seed = 32'hcc1d31c7;

  // Memory model, word index is address bits 5:2
  lsu_pkg::word_t    mem [MEM_WORDS];
  lsu_pkg::word_t    rsp_data_q [$];
  int                rsp_due_q [$];
  int                cycle;
  int                last_due;

  lsu_top dut0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_valid_i     (req_valid),
    .req_i           (req),
    .req_ready_o     (req_ready),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_o       (mem_req),
    .mem_req_ready_i (mem_req_ready),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_rdata_i (mem_rsp_rdata),
    .rsp_valid_o     (rsp_valid),
    .rsp_rdata_o     (rsp_rdata),
    .busy_o          (busy)
  );

  lsu_checker chk0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_valid_i     (req_valid),
    .req_i           (req),
    .req_ready_i     (req_ready),
    .mem_req_valid_i (mem_req_valid),
    .mem_req_i       (mem_req),
    .mem_req_ready_i (mem_req_ready),
    .rsp_valid_i     (rsp_valid),
    .rsp_rdata_i     (rsp_rdata),
    .busy_i          (busy),
    .drain_i         (drain),
    .mismatch_cnt_o  (mismatch_cnt),
    .other_err_cnt_o (other_err_cnt),
    .pending_o       (pending),
    .results_o       (results)
  );

  function automatic logic [7:0] init_byte(input int b);
    return 8'(b * 29 + 91);
  endfunction

  //////////////////////////////////////////////////
  // Clock, reset and watchdog
  //////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
  end

  initial
  begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////

  // Writes land at grant, responses follow in order after 1 to 3 cycles
  initial
  begin
    int widx;
    int due;
    for (int w = 0; w < MEM_WORDS; w++)
      for (int j = 0; j < 4; j++)
        mem[w][8*j +: 8] = init_byte(4 * w + j);
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_rdata = '0;
    cycle         = 0;
    last_due      = 0;
    @(posedge rst_n);
    forever
    begin
      @(negedge clk);
      if (mem_rsp_valid)
      begin
        void'(rsp_data_q.pop_front());
        void'(rsp_due_q.pop_front());
      end
      if (mem_req_valid && mem_req_ready)
      begin
        widx = int'(mem_req.addr[5:2]);
        rsp_data_q.push_back(mem[widx]);
        if (mem_req.we)
          for (int j = 0; j < 4; j++)
            if (mem_req.be[j])
              mem[widx][8*j +: 8] = mem_req.wdata[8*j +: 8];
        due = cycle + 1 + int'(($random(seed) & 32'h7fffffff) % 3);
        // Keep responses in order, one per cycle at most
        if (due <= last_due)
          due = last_due + 1;
        last_due = due;
        rsp_due_q.push_back(due);
      end
      @(posedge clk);
      cycle = cycle + 1;
      #2;
      mem_req_ready = (($random(seed) & 3) != 0);
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle)
      begin
        mem_rsp_valid = 1'b1;
        mem_rsp_rdata = rsp_data_q[0];
      end
      else
        mem_rsp_valid = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Core stimulus and end of run
  //////////////////////////////////////////////////

  initial
  begin
    lsu_pkg::lsu_req_t op;
    logic [5:0]        addr;
    int                total_errs;
    req_valid = 1'b0;
    req       = '0;
    drain     = 1'b0;
    @(posedge rst_n);
    // Idle cycles so the rest state after reset is seen
    repeat (3) @(posedge clk);
    #2;
    for (int i = 0; i < NUM_OPS; i++)
    begin
      op.size  = lsu_pkg::size_t'(($random(seed) & 32'h7fffffff) % 3);
      op.sext  = 1'($random(seed));
      op.we    = 1'($random(seed));
      addr     = 6'($random(seed));
      op.op_a  = $random(seed);
      op.op_b  = {26'h0, addr} - op.op_a;
      op.wdata = $random(seed);
      req       = op;
      req_valid = 1'b1;
      // Hold the operation until it is accepted
      @(negedge clk);
      while (!req_ready)
        @(negedge clk);
      @(posedge clk);
      #2;
      req_valid = 1'b0;
      if (($random(seed) & 3) == 0)
      begin
        @(posedge clk);
        #2;
      end
    end
    // All results back, then the unit has to go quiet
    @(posedge clk);
    while (pending != 0)
      @(posedge clk);
    #2;
    drain = 1'b1;
    repeat (3) @(posedge clk);
    total_errs = mismatch_cnt + other_err_cnt + dut0.u_lsu_assertions.fail_count;
    $display("Results %0d, mismatches %0d, other errors %0d, assertion failures %0d",
             results, mismatch_cnt, other_err_cnt, dut0.u_lsu_assertions.fail_count);
    if (total_errs == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- lsu_top.f
common/lsu_pkg.sv
common/mem_pkg.sv
logic/outstanding_cnt.sv
lsu/lsu_split_fsm.sv
lsu/lsu_req_align.sv
lsu/lsu_rdata_align.sv
lsu/lsu_top.sv
dv/lsu_assertions.sv
dv/lsu_checker.sv
dv/lsu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module lsu_tb -f lsu_top.f -Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Let failed assertions be counted instead of stopping the run
./obj_dir/lsu_sim +verilator+error+limit+100000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  exit 1
fi
exit 0
